//--- all.f
hdl/plot_pkg.sv
hdl/video_timing_pkg.sv
hdl/plot_if.sv
hdl/adc_sampler.sv
hdl/plot_source.sv
hdl/frame_buffer.sv
hdl/raster_scan.sv
hdl/adc_xy_display.sv
sim/tb_adc_xy_display.sv

//--- hdl/adc_sampler.sv
module adc_sampler
  import plot_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              adc_strobe,
  input  adc_sample_t       adc_x_bus,
  input  adc_sample_t       adc_y_bus,
  output logic [x_bits-1:0] sample_x,
  output logic [y_bits-1:0] sample_y,
  output logic              sample_valid
);

  adc_sample_t adc_x_q;
  adc_sample_t adc_y_q;
  logic        strobe_q;

  // capture stage, raw codes
  always_ff @(posedge clk) begin
    if (adc_strobe) begin
      adc_x_q <= adc_x_bus;
      adc_y_q <= adc_y_bus;
    end
  end

  // scale stage, keep the top bits of each code
  always_ff @(posedge clk) begin
    if (strobe_q) begin
      sample_x <= adc_x_q[adc_bits-1 -: x_bits];
      sample_y <= adc_y_q[adc_bits-1 -: y_bits];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_q     <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      strobe_q     <= adc_strobe;
      sample_valid <= strobe_q;
    end
  end

  // a fresh sample never carries unknown coordinates
  assert property (@(posedge clk) disable iff (reset)
    sample_valid |-> !$isunknown({sample_x, sample_y}));

endmodule

//--- hdl/adc_xy_display.sv
module adc_xy_display
  import plot_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  adc_strobe,
  input  logic [adc_bits-1:0]   adc_x_bus,
  input  logic [adc_bits-1:0]   adc_y_bus,
  output logic [color_bits-1:0] vga_red,
  output logic [color_bits-1:0] vga_grn,
  output logic [color_bits-1:0] vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync
);

  logic [x_bits-1:0] sample_x;
  logic [y_bits-1:0] sample_y;
  logic              sample_valid;
  logic              rd_en;
  logic [x_bits-1:0] rd_x;
  logic [y_bits-1:0] rd_y;
  pixel_t            rd_data;

  plot_if #(.h_visible(h_visible), .v_visible(v_visible)) wr_if ();

  adc_sampler #(.h_visible(h_visible), .v_visible(v_visible)) u_adc_sampler (
    .clk         (clk),
    .reset       (reset),
    .adc_strobe  (adc_strobe),
    .adc_x_bus   (adc_x_bus),
    .adc_y_bus   (adc_y_bus),
    .sample_x    (sample_x),
    .sample_y    (sample_y),
    .sample_valid(sample_valid)
  );

  plot_source #(.h_visible(h_visible), .v_visible(v_visible)) u_plot_source (
    .clk         (clk),
    .reset       (reset),
    .sample_x    (sample_x),
    .sample_y    (sample_y),
    .sample_valid(sample_valid),
    .wr          (wr_if.source)
  );

  frame_buffer #(.h_visible(h_visible), .v_visible(v_visible)) u_frame_buffer (
    .clk    (clk),
    .wr     (wr_if.sink),
    .rd_en  (rd_en),
    .rd_x   (rd_x),
    .rd_y   (rd_y),
    .rd_data(rd_data)
  );

  raster_scan #(.h_visible(h_visible), .v_visible(v_visible)) u_raster_scan (
    .clk      (clk),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_data  (rd_data),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

//--- hdl/frame_buffer.sv
module frame_buffer
  import plot_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible),
  localparam int addr_bits = x_bits + y_bits,
  localparam int depth = h_visible * v_visible
) (
  input  logic              clk,
  plot_if.sink              wr,
  input  logic              rd_en,
  input  logic [x_bits-1:0] rd_x,
  input  logic [y_bits-1:0] rd_y,
  output pixel_t            rd_data
);

  pixel_t               mem [depth];
  logic [addr_bits-1:0] addr;
  logic                 we;

  // scanner owns the port during active pixels
  assign wr.ready = !rd_en;
  assign we       = wr.valid && wr.ready;

  // one address port, row major
  always_comb begin
    if (rd_en) begin
      addr = {rd_y, rd_x};
    end else begin
      addr = {wr.y, wr.x};
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wr.color;
    end
  end

  // read data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[addr];
    end
  end

  // write target lies inside the visible frame
  assert property (@(posedge clk)
    we |-> !$isunknown({wr.x, wr.y}) && int'(wr.x) < h_visible &&
           int'(wr.y) < v_visible);

endmodule

//--- hdl/plot_if.sv
interface plot_if
  import plot_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible)
) ();

  logic [x_bits-1:0] x;
  logic [y_bits-1:0] y;
  pixel_t            color;
  logic              valid;
  logic              ready;

  // pixel writer side
  modport source(output x, output y, output color, output valid, input ready);

  // memory side
  modport sink(input x, input y, input color, input valid, output ready);

endinterface

//--- hdl/plot_pkg.sv
package plot_pkg;

  // 4 bits per channel, packed r/g/b
  localparam int color_bits = 4;
  localparam int pixel_bits = 3 * color_bits;

  // red in the top nibble, then green, then blue
  typedef logic [pixel_bits-1:0] pixel_t;

  // raw converter width
  localparam int adc_bits = 10;

  // unsigned adc code
  typedef logic [adc_bits-1:0] adc_sample_t;

  // full intensity dot
  localparam pixel_t plot_color = '1;

  // background
  localparam pixel_t clear_color = '0;

endpackage

//--- hdl/plot_source.sv
module plot_source
  import plot_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible),
  localparam int addr_bits = x_bits + y_bits
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [x_bits-1:0] sample_x,
  input  logic [y_bits-1:0] sample_y,
  input  logic              sample_valid,
  plot_if.source            wr
);

  typedef enum logic [1:0] {st_idle, st_clear, st_plot} state_t;

  state_t               state;
  logic [addr_bits-1:0] clr_addr;
  logic                 pend;
  logic [x_bits-1:0]    pend_x;
  logic [y_bits-1:0]    pend_y;
  logic                 offer;
  logic [x_bits-1:0]    offer_x;
  logic [y_bits-1:0]    offer_y;
  logic                 xfer;
  logic                 launch;

  assign xfer = wr.valid && wr.ready;

  // new offer only into an open slot while the memory is free,
  // so a stalled offer is never replaced
  assign launch = (state == st_plot) && (pend || sample_valid) && wr.ready &&
                  (!offer || xfer);

  // sweep every address once after reset, then plot
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      clr_addr <= '0;
    end else begin
      case (state)
        st_idle: state <= st_clear;
        st_clear: begin
          if (xfer) begin
            if (&clr_addr) begin
              state <= st_plot;
            end else begin
              clr_addr <= clr_addr + 1'b1;
            end
          end
        end
        default: state <= st_plot;
      endcase
    end
  end

  // newest sample, held through the sweep too
  always_ff @(posedge clk) begin
    if (reset) begin
      pend <= 1'b0;
    end else if (launch) begin
      pend <= 1'b0;
    end else if (sample_valid) begin
      pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      pend_x <= sample_x;
      pend_y <= sample_y;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      offer <= 1'b0;
    end else if (launch) begin
      offer <= 1'b1;
    end else if (xfer) begin
      offer <= 1'b0;
    end
  end

  // a sample arriving right now beats the pending one
  always_ff @(posedge clk) begin
    if (launch) begin
      offer_x <= sample_valid ? sample_x : pend_x;
      offer_y <= sample_valid ? sample_y : pend_y;
    end
  end

  always_comb begin
    if (state == st_plot) begin
      wr.x     = offer_x;
      wr.y     = offer_y;
      wr.color = plot_color;
      wr.valid = offer;
    end else begin
      wr.x     = clr_addr[x_bits-1:0];
      wr.y     = clr_addr[addr_bits-1:x_bits];
      wr.color = clear_color;
      wr.valid = (state == st_clear);
    end
  end

  // stalled write keeps its payload and its valid
  assert property (@(posedge clk) disable iff (reset)
    wr.valid && !wr.ready |=> wr.valid && $stable(wr.x) && $stable(wr.y) &&
                              $stable(wr.color));

endmodule

//--- hdl/raster_scan.sv
module raster_scan
  import plot_pkg::*;
  import video_timing_pkg::*;
#(
  parameter int h_visible = 16,
  parameter int v_visible = 8,
  localparam int x_bits = $clog2(h_visible),
  localparam int y_bits = $clog2(v_visible)
) (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  rd_en,
  output logic [x_bits-1:0]     rd_x,
  output logic [y_bits-1:0]     rd_y,
  input  pixel_t                rd_data,
  output logic [color_bits-1:0] vga_red,
  output logic [color_bits-1:0] vga_grn,
  output logic [color_bits-1:0] vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync
);

  localparam logic [15:0] h_total  = line_total(h_visible);
  localparam logic [15:0] v_total  = frame_lines(v_visible);
  localparam logic [15:0] hs_start = 16'(h_visible + h_front);
  localparam logic [15:0] hs_end   = 16'(h_visible + h_front + h_sync);
  localparam logic [15:0] vs_start = 16'(v_visible + v_front);
  localparam logic [15:0] vs_end   = 16'(v_visible + v_front + v_sync);

  logic [15:0] col_cnt;
  logic [15:0] line_cnt;
  logic        active;
  logic        hs_raw;
  logic        vs_raw;
  logic        hs_q;
  logic        vs_q;
  logic        pix_active;

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt  <= '0;
      line_cnt <= '0;
    end else if (col_cnt == h_total - 16'd1) begin
      col_cnt  <= '0;
      line_cnt <= (line_cnt == v_total - 16'd1) ? 16'd0 : line_cnt + 16'd1;
    end else begin
      col_cnt <= col_cnt + 16'd1;
    end
  end

  assign active = (col_cnt < 16'(h_visible)) && (line_cnt < 16'(v_visible));
  assign hs_raw = (col_cnt >= hs_start && col_cnt < hs_end) ? sync_active : sync_idle;
  assign vs_raw = (line_cnt >= vs_start && line_cnt < vs_end) ? sync_active : sync_idle;

  // stage 1, read strobe and address
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en <= 1'b0;
      hs_q  <= sync_idle;
      vs_q  <= sync_idle;
    end else begin
      rd_en <= active;
      hs_q  <= hs_raw;
      vs_q  <= vs_raw;
    end
  end

  always_ff @(posedge clk) begin
    rd_x <= col_cnt[x_bits-1:0];
    rd_y <= line_cnt[y_bits-1:0];
  end

  // stage 2, lines up with rd_data
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_active <= 1'b0;
      vga_hsync  <= sync_idle;
      vga_vsync  <= sync_idle;
    end else begin
      pix_active <= rd_en;
      vga_hsync  <= hs_q;
      vga_vsync  <= vs_q;
    end
  end

  // black outside the visible window
  assign vga_red = pix_active ? rd_data[pixel_bits-1 -: color_bits] : '0;
  assign vga_grn = pix_active ? rd_data[2*color_bits-1 -: color_bits] : '0;
  assign vga_blu = pix_active ? rd_data[color_bits-1 -: color_bits] : '0;

  assert property (@(posedge clk) disable iff (reset)
    col_cnt < h_total && line_cnt < v_total);

endmodule

//--- hdl/video_timing_pkg.sv
package video_timing_pkg;

  // horizontal porch and sync, in clock cycles
  localparam int h_front = 2;
  localparam int h_sync  = 3;
  localparam int h_back  = 2;

  // vertical porch and sync, in lines
  localparam int v_front = 2;
  localparam int v_sync  = 2;
  localparam int v_back  = 2;

  // syncs are active low
  localparam logic sync_active = 1'b0;
  localparam logic sync_idle   = 1'b1;

  // cycles per line for a given visible width
  function automatic logic [15:0] line_total(int unsigned h_visible);
    return 16'(h_visible + h_front + h_sync + h_back);
  endfunction

  // lines per frame for a given visible height
  function automatic logic [15:0] frame_lines(int unsigned v_visible);
    return 16'(v_visible + v_front + v_sync + v_back);
  endfunction

endpackage

//--- sim/tb_adc_xy_display.sv
module tb_adc_xy_display;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int h_visible = 16;
  localparam int v_visible = 8;
  localparam int x_bits = $clog2(h_visible);
  localparam int y_bits = $clog2(v_visible);
  localparam int adc_width = 10;

  // 2 front porch, 3 sync, 2 back porch per line
  localparam int line_len = h_visible + 7;
  // 2 front porch, 2 sync, 2 back porch lines per frame
  localparam int frame_len = v_visible + 6;
  localparam int frame_cycles = line_len * frame_len;
  localparam int hs_first = h_visible + 2;
  localparam int hs_last = h_visible + 4;
  localparam int vs_first = v_visible + 2;
  localparam int vs_last = v_visible + 3;

  localparam int n_entries = 6;
  localparam int cycle_limit = frame_cycles * (2 * n_entries + 6);

  logic                 clk;
  logic                 reset;
  logic                 adc_strobe;
  logic [adc_width-1:0] adc_x_bus;
  logic [adc_width-1:0] adc_y_bus;
  logic [3:0]           vga_red;
  logic [3:0]           vga_grn;
  logic [3:0]           vga_blu;
  logic                 vga_hsync;
  logic                 vga_vsync;

  // raw adc codes; the pair entry strobes (x0,y0) then (x1,y1) back to back
  string entry_name [n_entries] = '{"origin", "far_corner", "mid_screen", "last_wins",
                                    "x_full_scale", "y_full_scale"};
  int    entry_x0 [n_entries]   = '{0, 1023, 520, 100, 1023, 0};
  int    entry_y0 [n_entries]   = '{0, 1023, 300, 900, 0, 1023};
  int    entry_x1 [n_entries]   = '{0, 0, 0, 700, 0, 0};
  int    entry_y1 [n_entries]   = '{0, 0, 0, 400, 0, 0};
  bit    entry_pair [n_entries] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  // expected screen contents
  logic [11:0] ref_fb [v_visible][h_visible];
  int unsigned cycles = 0;

  adc_xy_display #(.h_visible(h_visible), .v_visible(v_visible)) dut (
    .clk       (clk),
    .reset     (reset),
    .adc_strobe(adc_strobe),
    .adc_x_bus (adc_x_bus),
    .adc_y_bus (adc_y_bus),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display(">>> FAIL");
      $display("run did not finish within %0d clock cycles", cycle_limit);
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // keep the top bits, fill the discarded low bits with noise
  function automatic int unsigned with_noise(input int code, input int keep_bits);
    int unsigned low_mask;
    low_mask = (1 << (adc_width - keep_bits)) - 1;
    return (code & ~low_mask & 32'h3ff) | ($urandom & low_mask);
  endfunction

  function automatic int to_col(input int code);
    return code >> (adc_width - x_bits);
  endfunction

  function automatic int to_row(input int code);
    return code >> (adc_width - y_bits);
  endfunction

  task automatic plot_dot(input int code_x, input int code_y);
    ref_fb[to_row(code_y)][to_col(code_x)] = 12'hfff;
  endtask

  task automatic drive_strobe(input int code_x, input int code_y);
    @(posedge clk);
    #1;
    adc_strobe = 1'b1;
    adc_x_bus  = 10'(with_noise(code_x, x_bits));
    adc_y_bus  = 10'(with_noise(code_y, y_bits));
  endtask

  task automatic end_strobe();
    @(posedge clk);
    #1;
    adc_strobe = 1'b0;
  endtask

  task automatic check_idle_outputs(input string name);
    check_equal({name, " hsync"}, 32'd1, 32'(vga_hsync));
    check_equal({name, " vsync"}, 32'd1, 32'(vga_vsync));
    check_equal({name, " colour"}, 32'd0, 32'({vga_red, vga_grn, vga_blu}));
  endtask

  // strobes land a few cycles into line 0, while the scanner holds the memory
  task automatic apply_entry(input int i);
    drive_strobe(entry_x0[i], entry_y0[i]);
    if (entry_pair[i]) begin
      drive_strobe(entry_x1[i], entry_y1[i]);
      plot_dot(entry_x1[i], entry_y1[i]);
    end else begin
      plot_dot(entry_x0[i], entry_y0[i]);
    end
    end_strobe();
  endtask

  // leaves us at the falling clock edge that shows pixel (0,0)
  task automatic align_to_frame();
    logic prev;
    prev = vga_vsync;
    @(negedge clk);
    while (!(prev === 1'b1 && vga_vsync === 1'b0)) begin
      prev = vga_vsync;
      @(negedge clk);
    end
    // vsync falls at the start of line vs_first
    repeat ((frame_len - vs_first) * line_len) @(negedge clk);
  endtask

  task automatic compare_frame(input string name);
    logic [31:0] want;
    for (int line = 0; line < frame_len; line++) begin
      for (int col = 0; col < line_len; col++) begin
        if (col < h_visible && line < v_visible) begin
          want = 32'(ref_fb[line][col]);
        end else begin
          want = 32'd0;
        end
        check_equal($sformatf("%s pixel (%0d,%0d)", name, col, line), want,
                    32'({vga_red, vga_grn, vga_blu}));
        check_equal($sformatf("%s hsync (%0d,%0d)", name, col, line),
                    (col >= hs_first && col <= hs_last) ? 32'd0 : 32'd1, 32'(vga_hsync));
        check_equal($sformatf("%s vsync (%0d,%0d)", name, col, line),
                    (line >= vs_first && line <= vs_last) ? 32'd0 : 32'd1, 32'(vga_vsync));
        @(negedge clk);
      end
    end
  endtask

  initial begin
    reset      = 1'b1;
    adc_strobe = 1'b0;
    adc_x_bus  = '0;
    adc_y_bus  = '0;
    void'($urandom(32'h338ceaee));
    for (int r = 0; r < v_visible; r++) begin
      for (int c = 0; c < h_visible; c++) begin
        ref_fb[r][c] = 12'h000;
      end
    end

    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_idle_outputs("in reset");
    end
    reset = 1'b0;

    // first cycle out of reset, before any memory read reaches the colour
    @(posedge clk);
    #1;
    check_idle_outputs("after reset");

    // two samples during the sweep, only the newer one gets drawn
    drive_strobe(130, 150);
    end_strobe();
    drive_strobe(260, 650);
    end_strobe();
    plot_dot(260, 650);

    align_to_frame();
    repeat (frame_cycles) @(negedge clk);
    compare_frame("clear");

    for (int i = 0; i < n_entries; i++) begin
      fork
        apply_entry(i);
        repeat (frame_cycles) @(negedge clk);
      join
      compare_frame(entry_name[i]);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule
